//--- src.f
+incdir+test
hw/upd_timing_pkg.sv
hw/upd_isa_pkg.sv
hw/phase_gen.sv
hw/program_rom.sv
hw/pc_sequencer.sv
hw/instr_decoder.sv
hw/alu_datapath.sv
hw/port_io.sv
hw/upd_top.sv
test/upd_tb.sv

//--- rom.hex
// one 16-bit instruction word per line, from address 0
// top nibble is the opcode, low byte the operand, bit 8 the skip-on-carry flag
1000  // 0  IN A,PA
8135  // 1  ADI A,0x35 with skip
2000  // 2  OUT PB,A
1000  // 3  IN A,PA
B05A  // 4  XORI A,0x5A
2000  // 5  OUT PB,A
1000  // 6  IN A,PA
A081  // 7  ORI A,0x81
2000  // 8  OUT PB,A
1000  // 9  IN A,PA
9010  // 10 SBI A,0x10
2000  // 11 OUT PB,A
6000  // 12 JMP 0

//--- test/upd_tb_tasks.svh
// reset, PB capture, expected-value model and directed test tasks for upd_tb

`ifndef upd_tb_tasks_svh
`define upd_tb_tasks_svh

//////////////////////////////////////////////////
// common steps

task automatic apply_reset(input byte_t pa_val);
  @(negedge CLK);
  pa  = pa_val;                                    // held for the whole test
  rst = 1'b1;
  repeat (5) @(negedge CLK);
  rst = 1'b0;
endtask

// one sample per clock, strobe lasts exactly one clock
task automatic capture_writes(input int n_clks);
  got_q.delete();
  repeat (n_clks) begin
    @(negedge CLK);
    if (pb_strobe) begin
      got_q.push_back(pb);
    end
  end
endtask

// PB values of one pass through the program
task automatic predict_writes(input byte_t pa_val);
  logic [8:0] sum;
  exp_q.delete();
  sum = {1'b0, pa_val} + 9'h035;                   // ADI 0x35 with skip
  if (sum <= 9'd255) begin
    exp_q.push_back(sum[7:0]);                     // carry would skip this OUT
  end
  exp_q.push_back(pa_val ^ 8'h5a);
  exp_q.push_back(pa_val | 8'h81);
  exp_q.push_back(pa_val - 8'h10);                 // wraps on borrow, no skip
endtask

task automatic compare_writes(input string what);
  int n;
  assert (got_q.size() == exp_q.size()) else begin
    $display("%0t: %s gave %0d PB writes where %0d were expected",
             $time, what, got_q.size(), exp_q.size());
    err_count++;
  end
  n = (got_q.size() < exp_q.size()) ? got_q.size() : exp_q.size();
  for (int i = 0; i < n; i++) begin
    assert (got_q[i] == exp_q[i]) else begin
      $display("[ERROR] %0t: %s write %0d pb 0x%02h, expected 0x%02h",
               $time, what, i, got_q[i], exp_q[i]);
      err_count++;
    end
  end
endtask

task automatic finish_test(input string what, input int errs_before);
  tests_run++;
  if (err_count > errs_before) begin
    tests_failed++;
    $display("test %s: FAIL, %0d errors", what, err_count - errs_before);
  end else begin
    $display("test %s: ok", what);
  end
endtask

//////////////////////////////////////////////////
// directed tests

task automatic check_after_reset();
  int errs_before;
  errs_before = err_count;
  apply_reset(8'h00);
  assert (pb == '0 && !pb_strobe) else begin
    $display("[ERROR] %0t: after reset pb 0x%02h strobe %b", $time, pb, pb_strobe);
    err_count++;
  end
  capture_writes(2 * upd_timing_pkg::cycle_len);   // IN and ADI only
  assert (got_q.size() == 0) else begin
    $display("%0t: PB was written during the first two instructions", $time);
    err_count++;
  end
  assert (pb == '0) else begin
    $display("[ERROR] %0t: pb 0x%02h before any OUT", $time, pb);
    err_count++;
  end
  finish_test("reset state", errs_before);
endtask

task automatic fixed_pa_loop(input byte_t pa_val, input string what);
  int errs_before;
  errs_before = err_count;
  apply_reset(pa_val);
  capture_writes(loop_clks);
  predict_writes(pa_val);
  compare_writes(what);
  finish_test(what, errs_before);
endtask

task automatic random_pa_loop();
  logic [31:0] rnd;
  byte_t       pa_val;
  rnd    = $random(seed);
  pa_val = rnd[upd_isa_pkg::data_w-1:0];
  fixed_pa_loop(pa_val, $sformatf("random pa 0x%02h", pa_val));
endtask

task automatic repeat_loop_check(input byte_t pa_val);
  int errs_before;
  int n;
  errs_before = err_count;
  apply_reset(pa_val);
  capture_writes(2 * loop_clks);
  predict_writes(pa_val);
  n = exp_q.size();
  for (int i = 0; i < n; i++) begin
    exp_q.push_back(exp_q[i]);                     // second pass after JMP 0
  end
  compare_writes("two loops");
  finish_test("two loops", errs_before);
endtask

`endif

//--- test/upd_tb.sv
// upd_tb: clock, reset, watchdog, DUT instance, test sequence and summary

`timescale 1ns/10ps

module upd_tb;

  typedef logic [upd_isa_pkg::data_w-1:0] byte_t;

  localparam int clk_half  = 20;                   // 40 ns period
  localparam int num_rand  = 20;                   // random PA runs
  localparam int num_tests = 5 + num_rand;
  localparam int loop_clks = 13 * upd_timing_pkg::cycle_len; // 13 instructions

  logic  CLK;
  logic  rst;
  byte_t pa;
  byte_t pb;
  logic  pb_strobe;

  byte_t  got_q[$];                                // PB values seen at strobes
  byte_t  exp_q[$];                                // predicted PB values
  int     err_count;
  int     tests_run;
  int     tests_failed;
  integer seed;

  `include "upd_tb_tasks.svh"

  upd_top u_dut (.CLK, .rst, .pa, .pb, .pb_strobe);

  initial begin
    CLK = 1'b0;
  end

  always #clk_half CLK = ~CLK;

  //////////////////////////////////////////////////
  // watchdog

  initial begin
    #(num_tests * 200 * 2 * clk_half);
    $display("watchdog timeout: tests still running at %0t", $time);
    $display("Done: errors found");
    $finish;
  end

  //////////////////////////////////////////////////
  // test sequence

  initial begin
    rst          = 1'b1;
    pa           = '0;
    err_count    = 0;
    tests_run    = 0;
    tests_failed = 0;
    seed         = 32'he638_1bec;
    check_after_reset();
    fixed_pa_loop(8'h10, "pa 0x10 no carry");
    fixed_pa_loop(8'he0, "pa 0xe0 carry skips out");
    fixed_pa_loop(8'h05, "pa 0x05 sbi borrow");
    repeat (num_rand) random_pa_loop();
    repeat_loop_check(8'hcb);                      // jmp back to address 0
    $display("tests run: %0d, failed: %0d, errors: %0d", tests_run, tests_failed, err_count);
    if (err_count == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

//--- hw/upd_top.sv
// upd_top: CPU core top level connecting sequencer, ROM, decoder, ALU and ports

`timescale 1ns/10ps

module upd_top (
  input  logic       CLK,
  input  logic       rst,
  input  logic [7:0] pa,
  output logic [7:0] pb,
  output logic       pb_strobe
);

  logic [upd_timing_pkg::phase_w-1:0] phase;
  logic [upd_timing_pkg::rom_aw-1:0]  pc;
  logic [upd_timing_pkg::rom_aw-1:0]  jump_addr;
  logic [upd_isa_pkg::instr_w-1:0]    instr;
  logic [upd_isa_pkg::data_w-1:0]     imm;
  logic [upd_isa_pkg::data_w-1:0]     acc;
  logic [upd_isa_pkg::data_w-1:0]     pa_sync;
  upd_isa_pkg::alu_op_t               alu_op;
  logic                               load_imm;
  logic                               load_pa;
  logic                               write_pb;
  logic                               jump;
  logic                               skip_on_carry;
  logic                               skip_now;
  logic                               carry;

  //////////////////////////////////////////////////
  // sequencing

  phase_gen u_phase_gen (.CLK, .rst, .phase);

  program_rom u_program_rom (.CLK, .rst, .phase, .pc, .instr);

  pc_sequencer u_pc_sequencer (
    .CLK, .rst, .phase, .jump, .jump_addr, .skip_on_carry, .carry, .pc, .skip_now
  );

  instr_decoder u_instr_decoder (
    .instr, .skip_now, .alu_op, .load_imm, .load_pa, .write_pb, .jump,
    .skip_on_carry, .imm, .jump_addr
  );

  //////////////////////////////////////////////////
  // datapath and ports

  alu_datapath u_alu_datapath (
    .CLK, .rst, .phase, .alu_op, .load_imm, .load_pa, .imm, .pa_sync, .acc, .carry
  );

  port_io u_port_io (
    .CLK, .rst, .phase, .pa, .write_pb, .acc, .pa_sync, .pb, .pb_strobe
  );

endmodule

//--- hw/port_io.sv
// port_io: PA input synchronizer and PB output register with write strobe

`timescale 1ns/10ps

module port_io (
  input  logic                               CLK,
  input  logic                               rst,
  input  logic [upd_timing_pkg::phase_w-1:0] phase,
  input  logic [upd_isa_pkg::data_w-1:0]     pa,
  input  logic                               write_pb,
  input  logic [upd_isa_pkg::data_w-1:0]     acc,
  output logic [upd_isa_pkg::data_w-1:0]     pa_sync,
  output logic [upd_isa_pkg::data_w-1:0]     pb,
  output logic                               pb_strobe
);

  logic [upd_isa_pkg::data_w-1:0] pa_meta;         // first sync stage

  always_ff @(posedge CLK) begin
    pa_meta <= pa;
    pa_sync <= pa_meta;
  end

  //////////////////////////////////////////////////
  // PB register

  // loads on the edge into the write phase, so new data and strobe
  // are both present for the whole write phase
  always_ff @(posedge CLK) begin
    if (rst) begin
      pb        <= '0;
      pb_strobe <= 1'b0;
    end else begin
      pb_strobe <= 1'b0;
      if (phase == upd_timing_pkg::ph_write - 1'b1 && write_pb) begin
        pb        <= acc;
        pb_strobe <= 1'b1;
      end
    end
  end

  a_strobe_in_write: assert property (
    @(posedge CLK) disable iff (rst)
    pb_strobe |-> (phase == upd_timing_pkg::ph_write)
  ) else $error("pb_strobe outside the write phase");

endmodule

//--- hw/alu_datapath.sv
// alu_datapath: operand registers, 8-bit ALU, accumulator A and carry flag

`timescale 1ns/10ps

module alu_datapath (
  input  logic                               CLK,
  input  logic                               rst,
  input  logic [upd_timing_pkg::phase_w-1:0] phase,
  input  upd_isa_pkg::alu_op_t               alu_op,
  input  logic                               load_imm,
  input  logic                               load_pa,
  input  logic [upd_isa_pkg::data_w-1:0]     imm,
  input  logic [upd_isa_pkg::data_w-1:0]     pa_sync,
  output logic [upd_isa_pkg::data_w-1:0]     acc,
  output logic                               carry
);

  logic [upd_isa_pkg::data_w-1:0] op_a;            // copy of A
  logic [upd_isa_pkg::data_w-1:0] op_b;            // immediate or port value
  logic [upd_isa_pkg::data_w:0]   alu_res;         // bit 8 is carry/borrow
  logic                           write_a;

  assign write_a = load_imm | load_pa;

  //////////////////////////////////////////////////
  // operand registers

  always_ff @(posedge CLK) begin
    if (phase == upd_timing_pkg::ph_decode) begin
      op_a <= acc;
      op_b <= load_pa ? pa_sync : imm;
    end
  end

  //////////////////////////////////////////////////
  // ALU

  always_comb begin
    case (alu_op)
      upd_isa_pkg::alu_add: alu_res = {1'b0, op_a} + {1'b0, op_b};
      upd_isa_pkg::alu_sub: alu_res = {1'b0, op_a} - {1'b0, op_b}; // borrow when n > A
      upd_isa_pkg::alu_or:  alu_res = {1'b0, op_a | op_b};
      upd_isa_pkg::alu_xor: alu_res = {1'b0, op_a ^ op_b};
      default:              alu_res = {1'b0, op_b};               // MVI and IN
    endcase
  end

  //////////////////////////////////////////////////
  // accumulator and carry

  always_ff @(posedge CLK) begin
    if (rst) begin
      acc   <= '0;
      carry <= 1'b0;
    end else if (phase == upd_timing_pkg::ph_exec && write_a) begin
      acc <= alu_res[upd_isa_pkg::data_w-1:0];
      if (alu_op != upd_isa_pkg::alu_pass) begin
        carry <= alu_res[upd_isa_pkg::data_w];     // or/xor give 0 here
      end
    end
  end

  //////////////////////////////////////////////////
  // checks

  a_logic_clears_carry: assert property (
    @(posedge CLK) disable iff (rst)
    (phase == upd_timing_pkg::ph_exec && write_a &&
     (alu_op == upd_isa_pkg::alu_or || alu_op == upd_isa_pkg::alu_xor)) |=> !carry
  ) else $error("carry set after ORI/XORI");

endmodule

//--- hw/instr_decoder.sv
// instr_decoder: decode of the opcode nibble into datapath and sequencer controls

`timescale 1ns/10ps

module instr_decoder (
  input  logic [upd_isa_pkg::instr_w-1:0]   instr,
  input  logic                              skip_now,
  output upd_isa_pkg::alu_op_t              alu_op,
  output logic                              load_imm,
  output logic                              load_pa,
  output logic                              write_pb,
  output logic                              jump,
  output logic                              skip_on_carry,
  output logic [upd_isa_pkg::data_w-1:0]    imm,
  output logic [upd_timing_pkg::rom_aw-1:0] jump_addr
);

  logic [upd_isa_pkg::op_w-1:0] opcode;

  assign opcode    = instr[upd_isa_pkg::op_lsb +: upd_isa_pkg::op_w];
  assign imm       = instr[upd_isa_pkg::data_w-1:0];      // low byte
  assign jump_addr = instr[upd_timing_pkg::rom_aw-1:0];   // low 9 bits

  always_comb begin
    alu_op        = upd_isa_pkg::alu_pass;
    load_imm      = 1'b0;
    load_pa       = 1'b0;
    write_pb      = 1'b0;
    jump          = 1'b0;
    skip_on_carry = 1'b0;
    if (!skip_now) begin                           // skipped word acts as NOP
      case (opcode)
        upd_isa_pkg::op_nop: ;                     // idle cycle
        upd_isa_pkg::op_in:  load_pa  = 1'b1;
        upd_isa_pkg::op_out: write_pb = 1'b1;
        upd_isa_pkg::op_mvi: load_imm = 1'b1;
        upd_isa_pkg::op_jmp: jump     = 1'b1;
        upd_isa_pkg::op_adi: begin
          alu_op        = upd_isa_pkg::alu_add;
          load_imm      = 1'b1;
          skip_on_carry = instr[upd_isa_pkg::skip_bit];
        end
        upd_isa_pkg::op_sbi: begin
          alu_op        = upd_isa_pkg::alu_sub;
          load_imm      = 1'b1;
          skip_on_carry = instr[upd_isa_pkg::skip_bit];
        end
        upd_isa_pkg::op_ori: begin
          alu_op   = upd_isa_pkg::alu_or;
          load_imm = 1'b1;
        end
        upd_isa_pkg::op_xori: begin
          alu_op   = upd_isa_pkg::alu_xor;
          load_imm = 1'b1;
        end
        default: ;                                 // unused opcodes, no effect
      endcase
    end
  end

endmodule

//--- hw/pc_sequencer.sv
// pc_sequencer: program counter, jump load and pending instruction skip

`timescale 1ns/10ps

module pc_sequencer (
  input  logic                               CLK,
  input  logic                               rst,
  input  logic [upd_timing_pkg::phase_w-1:0] phase,
  input  logic                               jump,
  input  logic [upd_timing_pkg::rom_aw-1:0]  jump_addr,
  input  logic                               skip_on_carry,
  input  logic                               carry,
  output logic [upd_timing_pkg::rom_aw-1:0]  pc,
  output logic                               skip_now
);

  logic skip_pend;                                 // skip armed for next instruction

  //////////////////////////////////////////////////
  // program counter

  always_ff @(posedge CLK) begin
    if (rst) begin
      pc <= '0;
    end else if (phase == upd_timing_pkg::ph_write) begin
      if (jump) begin
        pc <= jump_addr;
      end else begin
        pc <= pc + 1'b1;                           // wraps at rom_depth
      end
    end
  end

  //////////////////////////////////////////////////
  // skip flag

  // carry from the ADI/SBI has settled by the write phase. The flag is
  // reloaded at every write phase, so it lives for one instruction only
  always_ff @(posedge CLK) begin
    if (rst) begin
      skip_pend <= 1'b0;
    end else if (phase == upd_timing_pkg::ph_write) begin
      skip_pend <= skip_on_carry & carry;
    end
  end

  assign skip_now = skip_pend;

  //////////////////////////////////////////////////
  // checks

  // a skipped instruction must not arm another skip
  a_no_double_skip: assert property (
    @(posedge CLK) disable iff (rst)
    (phase == upd_timing_pkg::ph_write && skip_now) |=> !skip_now
  ) else $error("skip held across two instructions");

endmodule

//--- hw/program_rom.sv
// program_rom: program ROM array, read buffer and registered instruction word

`timescale 1ns/10ps

module program_rom (
  input  logic                               CLK,
  input  logic                               rst,
  input  logic [upd_timing_pkg::phase_w-1:0] phase,
  input  logic [upd_timing_pkg::rom_aw-1:0]  pc,
  output logic [upd_isa_pkg::instr_w-1:0]    instr
);

  logic [upd_isa_pkg::instr_w-1:0] rom_mem [upd_timing_pkg::rom_depth];
  logic [upd_isa_pkg::instr_w-1:0] rom_rbuf;      // word at current pc

  initial begin
    $readmemh("rom.hex", rom_mem);
  end

  always_ff @(posedge CLK) begin
    rom_rbuf <= rom_mem[pc];                       // follows pc every clock
  end

  always_ff @(posedge CLK) begin
    if (rst) begin
      instr <= {upd_isa_pkg::op_nop, {(upd_isa_pkg::instr_w - upd_isa_pkg::op_w){1'b0}}};
    end else if (phase == upd_timing_pkg::ph_fetch) begin
      instr <= rom_rbuf;                           // held for the whole cycle
    end
  end

endmodule

//--- hw/phase_gen.sv
// phase_gen: divide-by-eight phase counter giving the instruction phases

`timescale 1ns/10ps

module phase_gen (
  input  logic                               CLK,
  input  logic                               rst,
  output logic [upd_timing_pkg::phase_w-1:0] phase
);

  //////////////////////////////////////////////////
  // phase counter

  always_ff @(posedge CLK) begin
    if (rst) begin
      phase <= '0;
    end else if (phase == upd_timing_pkg::cycle_len - 1) begin
      phase <= '0;                                 // end of instruction
    end else begin
      phase <= phase + 1'b1;
    end
  end

  //////////////////////////////////////////////////
  // checks

  // one step per clock, wrapping into the next instruction
  a_phase_step: assert property (
    @(posedge CLK) disable iff (rst)
    !$past(rst) |-> (phase == $past(phase) + 1'b1)
  ) else $error("phase did not advance by one");

endmodule

//--- hw/upd_isa_pkg.sv
// instruction and data widths, opcode values, field positions and ALU operation codes

package upd_isa_pkg;

  //////////////////////////////////////////////////
  // widths

  localparam int instr_w = 16;
  localparam int data_w  = 8;

  //////////////////////////////////////////////////
  // instruction fields

  localparam int op_w     = 4;                    // opcode nibble
  localparam int op_lsb   = 12;                   // opcode sits in bits 15:12
  localparam int skip_bit = 8;                    // skip next on carry, ADI and SBI only

  //////////////////////////////////////////////////
  // opcode nibble values

  localparam logic [op_w-1:0] op_nop  = 4'h0;
  localparam logic [op_w-1:0] op_in   = 4'h1;     // A <- PA
  localparam logic [op_w-1:0] op_out  = 4'h2;     // PB <- A
  localparam logic [op_w-1:0] op_mvi  = 4'h4;     // A <- n
  localparam logic [op_w-1:0] op_jmp  = 4'h6;     // PC <- low address bits
  localparam logic [op_w-1:0] op_adi  = 4'h8;
  localparam logic [op_w-1:0] op_sbi  = 4'h9;
  localparam logic [op_w-1:0] op_ori  = 4'hA;
  localparam logic [op_w-1:0] op_xori = 4'hB;

  //////////////////////////////////////////////////
  // ALU operations

  // pass moves operand B to A without touching carry
  typedef enum logic [2:0] {
    alu_add,
    alu_sub,
    alu_or,
    alu_xor,
    alu_pass
  } alu_op_t;

endpackage

//--- hw/upd_timing_pkg.sv
// instruction cycle length, phase numbers and program ROM geometry

package upd_timing_pkg;

  //////////////////////////////////////////////////
  // instruction cycle

  localparam int cycle_len = 8;                    // clocks per instruction
  localparam int phase_w   = $clog2(cycle_len);    // phase counter width

  // phases at which each step of an instruction happens
  localparam logic [phase_w-1:0] ph_fetch  = 3'd1; // ROM word latches into instr
  localparam logic [phase_w-1:0] ph_decode = 3'd2; // operand registers load
  localparam logic [phase_w-1:0] ph_exec   = 3'd4; // A and flags update
  localparam logic [phase_w-1:0] ph_write  = 3'd6; // PB written, PC advances

  //////////////////////////////////////////////////
  // program ROM

  localparam int rom_depth = 512;                  // words
  localparam int rom_aw    = $clog2(rom_depth);    // PC width

endpackage
